//--- verilog/cache_pkg.sv
package cache_pkg;

	// address and data widths
	localparam int ADDR_W = 16;
	localparam int WORD_W = 16;

	// address split: tag | set index | byte offset
	localparam int TAG_W    = 5;
	localparam int INDEX_W  = 7;
	localparam int OFFSET_W = 4;

	// geometry
	localparam int NUM_SETS        = 128; // one block per set
	localparam int WORDS_PER_BLOCK = 8;
	localparam int WORD_SEL_W      = 3;   // offset[3:1] picks the word

	typedef logic [ADDR_W-1:0]  addr_t;
	typedef logic [WORD_W-1:0]  word_t;
	typedef logic [TAG_W-1:0]   tag_t;
	typedef logic [INDEX_W-1:0] index_t;

	// one metadata entry per set, 6 bits
	typedef struct packed {
		logic valid; // block holds memory contents
		tag_t tag;   // upper address bits of the cached block
	} meta_t;

endpackage

//--- verilog/set_array.sv
`timescale 1ns/1ps

module set_array #(
	parameter type entry_t     = cache_pkg::meta_t,
	parameter bit  reset_clear = 1'b0
) (
	input  logic              clk,
	input  logic              reset,
	input  cache_pkg::index_t index,
	input  logic              write,
	input  entry_t            write_entry,
	output entry_t            read_entry
);
	import cache_pkg::*;

	entry_t entries [NUM_SETS]; // one entry per set

	always_ff @(posedge clk) begin
		if (reset_clear && reset) begin // only the metadata instance clears
			for (int i = 0; i < NUM_SETS; i++) begin
				entries[i] <= '0; // drops every valid bit
			end
		end else if (write) begin
			entries[index] <= write_entry;
		end
	end

	// lookup is combinational so a hit answers in the request cycle
	assign read_entry = entries[index];

endmodule

//--- verilog/cache_fill_fsm.sv
`timescale 1ns/1ps

module cache_fill_fsm (
	input  logic                             clk,
	input  logic                             reset,
	input  logic                             miss,           // request missed in the cache
	input  logic                             grant,          // arbiter gives us the port
	input  cache_pkg::addr_t                 miss_addr,
	input  logic                             mem_data_valid, // one word back from memory
	output logic                             fill_busy,
	output logic                             mem_read,
	output cache_pkg::addr_t                 mem_addr,
	output logic                             write_data_array,
	output logic [cache_pkg::WORD_SEL_W-1:0] fill_word,
	output cache_pkg::addr_t                 base_addr,
	output logic                             write_tag
);
	import cache_pkg::*;

	typedef enum logic [1:0] {
		st_idle,   // waiting for a granted miss
		st_fill,   // issue reads and collect responses
		st_finish  // write the tag
	} state_t;

	state_t                state;
	logic [WORD_SEL_W:0]   req_count;  // extra msb flags all eight issued
	logic [WORD_SEL_W-1:0] resp_count; // next word slot to fill
	logic                  start;

	assign start = (state == st_idle) && miss && grant;

	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= st_idle;
			req_count  <= '0;
			resp_count <= '0;
		end else begin
			case (state)
				st_idle: begin
					req_count  <= '0;
					resp_count <= '0;
					if (start) begin
						state <= st_fill;
					end
				end
				st_fill: begin
					if (mem_read) begin
						req_count <= req_count + 1'b1; // one request per granted cycle
					end
					if (mem_data_valid) begin
						resp_count <= resp_count + 1'b1;
						if (resp_count == WORD_SEL_W'(WORDS_PER_BLOCK - 1)) begin
							state <= st_finish; // last word lands at this edge
						end
					end
				end
				st_finish: state <= st_idle;
				default:   state <= st_idle;
			endcase
		end
	end

	// block base, offset bits cleared
	always_ff @(posedge clk) begin
		if (start) begin
			base_addr <= {miss_addr[ADDR_W-1:OFFSET_W], OFFSET_W'(0)};
		end
	end

	assign fill_busy        = (state != st_idle);
	assign mem_read         = (state == st_fill) && grant && !req_count[WORD_SEL_W];
	assign mem_addr         = {base_addr[ADDR_W-1:OFFSET_W], req_count[WORD_SEL_W-1:0], 1'b0};
	assign write_data_array = (state == st_fill) && mem_data_valid; // responses come in order
	assign fill_word        = resp_count;
	assign write_tag        = (state == st_finish);

endmodule

//--- verilog/cache.sv
`timescale 1ns/1ps

module cache (
	input  logic             clk,
	input  logic             reset,
	input  logic             read,
	input  logic             write,
	input  cache_pkg::addr_t addr,
	input  cache_pkg::word_t write_data,
	output cache_pkg::word_t read_data,
	output logic             stall,
	input  logic             grant,
	input  logic             write_block,    // arbiter holds a store
	input  logic             mem_data_valid,
	input  cache_pkg::word_t mem_read_data,
	output logic             fill_busy,      // miss pending or fill running
	output logic             mem_read,
	output logic             mem_write,
	output logic             finish,
	output cache_pkg::addr_t mem_addr,
	output cache_pkg::word_t mem_write_data
);
	import cache_pkg::*;

	logic                       fsm_busy;
	logic                       fsm_write_data;
	logic                       fsm_write_tag;
	logic [WORD_SEL_W-1:0]      fill_word;
	addr_t                      base_addr;
	addr_t                      fsm_mem_addr;
	addr_t                      array_addr;
	index_t                     index;
	tag_t                       req_tag;
	logic [WORD_SEL_W-1:0]      req_word;
	meta_t                      meta_rd;
	meta_t                      meta_wr;
	word_t                      word_rd [WORDS_PER_BLOCK];
	word_t                      word_wd;
	logic [WORDS_PER_BLOCK-1:0] word_we;
	logic                       hit;
	logic                       miss;
	logic                       store_en;

	// addr: ttttt sssssss wwwb
	assign array_addr = fsm_busy ? base_addr : addr; // fill owns the arrays
	assign index      = array_addr[OFFSET_W +: INDEX_W];
	assign req_tag    = addr[ADDR_W-1 -: TAG_W];
	assign req_word   = addr[OFFSET_W-1:1]; // byte bit ignored

	assign hit      = meta_rd.valid && (meta_rd.tag == req_tag);
	assign miss     = (read || write) && !hit;
	assign store_en = write && hit && !write_block; // write-through happens now
	assign stall    = miss || fsm_busy || (write && write_block);

	cache_fill_fsm u_fill (
		.clk              (clk),
		.reset            (reset),
		.miss             (miss),
		.grant            (grant),
		.miss_addr        (addr),
		.mem_data_valid   (mem_data_valid),
		.fill_busy        (fsm_busy),
		.mem_read         (mem_read),
		.mem_addr         (fsm_mem_addr),
		.write_data_array (fsm_write_data),
		.fill_word        (fill_word),
		.base_addr        (base_addr),
		.write_tag        (fsm_write_tag)
	);

	assign meta_wr = '{valid: 1'b1, tag: base_addr[ADDR_W-1 -: TAG_W]};

	set_array #(.entry_t(meta_t), .reset_clear(1'b1)) u_meta (
		.clk         (clk),
		.reset       (reset),
		.index       (index),
		.write       (fsm_write_tag),
		.write_entry (meta_wr),
		.read_entry  (meta_rd)
	);

	assign word_wd = fsm_write_data ? mem_read_data : write_data; // never both at once

	for (genvar w = 0; w < WORDS_PER_BLOCK; w++) begin : g_word
		assign word_we[w] = (fsm_write_data && (fill_word == WORD_SEL_W'(w))) ||
			(store_en && (req_word == WORD_SEL_W'(w)));

		set_array #(.entry_t(word_t), .reset_clear(1'b0)) u_data (
			.clk         (clk),
			.reset       (reset),
			.index       (index),
			.write       (word_we[w]),
			.write_entry (word_wd),
			.read_entry  (word_rd[w])
		);
	end

	assign read_data = word_rd[req_word];

	// memory side
	assign fill_busy      = miss || fsm_busy; // doubles as arbiter request
	assign mem_write      = store_en;
	assign mem_addr       = fsm_busy ? fsm_mem_addr : addr;
	assign mem_write_data = write_data;
	assign finish         = fsm_write_tag;

endmodule

//--- verilog/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
	input  logic             clk,
	input  logic             reset,
	input  logic             i_fill_busy_req,
	input  logic             d_fill_busy_req,
	input  logic             i_finish,
	input  logic             d_finish,
	input  logic             i_mem_read,
	input  logic             d_mem_read,
	input  cache_pkg::addr_t i_mem_addr,
	input  cache_pkg::addr_t d_mem_addr,
	input  logic             d_mem_write,
	input  cache_pkg::word_t d_mem_write_data,
	output logic             i_grant,
	output logic             d_grant,
	output logic             d_write_block,
	output logic             i_mem_data_valid,
	output logic             d_mem_data_valid,
	output logic             mem_read,
	output logic             mem_write,
	output cache_pkg::addr_t mem_addr,
	output cache_pkg::word_t mem_write_data,
	input  logic             mem_data_valid
);
	typedef enum logic [1:0] {
		own_none, // port free
		own_i,    // instruction fill
		own_d     // data fill
	} owner_t;

	owner_t owner;

	always_ff @(posedge clk) begin
		if (reset) begin
			owner <= own_none;
		end else begin
			case (owner)
				own_none: begin
					if (d_fill_busy_req) begin // data side wins a tie
						owner <= own_d;
					end else if (i_fill_busy_req) begin
						owner <= own_i;
					end
				end
				own_i: if (i_finish) owner <= own_none;
				own_d: if (d_finish) owner <= own_none;
				default: owner <= own_none;
			endcase
		end
	end

	// grant shows up in the idle cycle so the fill starts one edge later
	assign d_grant = (owner == own_d) || ((owner == own_none) && d_fill_busy_req);
	assign i_grant = (owner == own_i) ||
		((owner == own_none) && i_fill_busy_req && !d_fill_busy_req);

	assign d_write_block = (owner == own_i); // store would collide with i reads

	assign i_mem_data_valid = mem_data_valid && (owner == own_i);
	assign d_mem_data_valid = mem_data_valid && (owner == own_d);

	assign mem_read       = (owner == own_i) ? i_mem_read : ((owner == own_d) && d_mem_read);
	assign mem_write      = d_mem_write; // already gated by write_block in the cache
	assign mem_addr       = (owner == own_i) ? i_mem_addr : d_mem_addr;
	assign mem_write_data = d_mem_write_data;

endmodule

//--- verilog/memory_system.sv
`timescale 1ns/1ps

module memory_system (
	input  logic             clk,
	input  logic             reset,
	input  logic             i_read,
	input  cache_pkg::addr_t i_addr,
	output cache_pkg::word_t i_read_data,
	output logic             i_stall,
	input  logic             d_read,
	input  logic             d_write,
	input  cache_pkg::addr_t d_addr,
	input  cache_pkg::word_t d_write_data,
	output cache_pkg::word_t d_read_data,
	output logic             d_stall,
	output logic             mem_read,
	output logic             mem_write,
	output cache_pkg::addr_t mem_addr,
	output cache_pkg::word_t mem_write_data,
	input  logic             mem_data_valid,
	input  cache_pkg::word_t mem_read_data
);
	import cache_pkg::*;

	logic  i_fill_busy, i_mem_read, i_finish, i_grant, i_mem_data_valid;
	addr_t i_mem_addr;
	logic  d_fill_busy, d_mem_read, d_mem_write, d_finish, d_grant, d_mem_data_valid;
	logic  d_write_block;
	addr_t d_mem_addr;
	word_t d_mem_write_data;

	cache u_icache (
		.clk (clk), .reset (reset),
		.read (i_read), .write (1'b0), // read only port
		.addr (i_addr), .write_data ('0),
		.read_data (i_read_data), .stall (i_stall),
		.grant (i_grant), .write_block (1'b0),
		.mem_data_valid (i_mem_data_valid), .mem_read_data (mem_read_data),
		.fill_busy (i_fill_busy), .mem_read (i_mem_read),
		.mem_write (), .finish (i_finish), // never stores
		.mem_addr (i_mem_addr), .mem_write_data ()
	);

	cache u_dcache (
		.clk (clk), .reset (reset),
		.read (d_read), .write (d_write),
		.addr (d_addr), .write_data (d_write_data),
		.read_data (d_read_data), .stall (d_stall),
		.grant (d_grant), .write_block (d_write_block),
		.mem_data_valid (d_mem_data_valid), .mem_read_data (mem_read_data),
		.fill_busy (d_fill_busy), .mem_read (d_mem_read),
		.mem_write (d_mem_write), .finish (d_finish),
		.mem_addr (d_mem_addr), .mem_write_data (d_mem_write_data)
	);

	mem_arbiter u_arbiter (
		.clk (clk), .reset (reset),
		.i_fill_busy_req (i_fill_busy), .d_fill_busy_req (d_fill_busy),
		.i_finish (i_finish), .d_finish (d_finish),
		.i_mem_read (i_mem_read), .d_mem_read (d_mem_read),
		.i_mem_addr (i_mem_addr), .d_mem_addr (d_mem_addr),
		.d_mem_write (d_mem_write), .d_mem_write_data (d_mem_write_data),
		.i_grant (i_grant), .d_grant (d_grant), .d_write_block (d_write_block),
		.i_mem_data_valid (i_mem_data_valid), .d_mem_data_valid (d_mem_data_valid),
		.mem_read (mem_read), .mem_write (mem_write),
		.mem_addr (mem_addr), .mem_write_data (mem_write_data),
		.mem_data_valid (mem_data_valid)
	);

endmodule

//--- test/memory_system_assertions.sv
`timescale 1ns/1ps

module memory_system_assertions (
	input logic clk,
	input logic reset,
	input logic mem_read,
	input logic mem_write,
	input logic i_finish,
	input logic d_finish,
	input logic i_fsm_busy, // fill machine state, not the arbiter request
	input logic d_fsm_busy,
	input logic i_grant,
	input logic d_grant
);
	int fail_count = 0; // peeked by the testbench summary

	// one word-wide port, so a read and a write cannot share a cycle
	port_exclusive: assert property (@(posedge clk) disable iff (reset)
		!(mem_read && mem_write))
		else begin
			$error("memory read and write requested in the same cycle");
			fail_count++;
		end

	// tag write must land while the arbiter still holds the port for this fill
	i_finish_in_fill: assert property (@(posedge clk) disable iff (reset)
		i_finish |-> i_grant)
		else begin
			$error("instruction finish pulse while its fill does not own the port");
			fail_count++;
		end

	d_finish_in_fill: assert property (@(posedge clk) disable iff (reset)
		d_finish |-> d_grant)
		else begin
			$error("data finish pulse while its fill does not own the port");
			fail_count++;
		end

	i_grant_held: assert property (@(posedge clk) disable iff (reset)
		(i_fsm_busy && $past(i_fsm_busy)) |-> $stable(i_grant))
		else begin
			$error("instruction grant changed during a fill");
			fail_count++;
		end

	d_grant_held: assert property (@(posedge clk) disable iff (reset)
		(d_fsm_busy && $past(d_fsm_busy)) |-> $stable(d_grant))
		else begin
			$error("data grant changed during a fill");
			fail_count++;
		end

endmodule

bind memory_system memory_system_assertions u_assertions (
	.clk        (clk),
	.reset      (reset),
	.mem_read   (mem_read),
	.mem_write  (mem_write),
	.i_finish   (i_finish),
	.d_finish   (d_finish),
	.i_fsm_busy (u_icache.fsm_busy),
	.d_fsm_busy (u_dcache.fsm_busy),
	.i_grant    (i_grant),
	.d_grant    (d_grant)
);

//--- test/memory_system_tb.sv
`timescale 1ns/1ps

module memory_system_tb;
	import cache_pkg::*;

	localparam int          MEM_LATENCY        = 4;
	localparam logic [31:0] LFSR_SEED          = 32'h977c_f1cb;
	localparam int          RANDOM_OPS         = 60;
	localparam int          REQUESTS           = 17 + 5 + 4 + 2 + 3 + RANDOM_OPS; // per test
	localparam int          CYCLES_PER_REQUEST = 200;

	logic  clk;
	logic  reset;
	logic  i_read;
	addr_t i_addr;
	word_t i_read_data;
	logic  i_stall;
	logic  d_read;
	logic  d_write;
	addr_t d_addr;
	word_t d_write_data;
	word_t d_read_data;
	logic  d_stall;
	logic  mem_read;
	logic  mem_write;
	addr_t mem_addr;
	word_t mem_write_data;
	logic  mem_data_valid;
	word_t mem_read_data;

	word_t       mem    [1 << (ADDR_W - 1)]; // memory model, one entry per word
	word_t       mirror [1 << (ADDR_W - 1)]; // predicted memory contents
	addr_t       pend_addr [$];              // reads in flight, oldest first
	int          pend_due  [$];
	int          cycle = 0;
	int          write_count = 0;
	addr_t       last_write_addr;
	word_t       last_write_data;
	logic [31:0] lfsr = LFSR_SEED;
	int          errors = 0;
	int          checks = 0;
	int          tests = 0;

	memory_system u_memory_system (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	// requests seen at the edge, writes land at once
	always @(posedge clk) begin
		cycle++;
		if (reset) begin
			pend_addr.delete();
			pend_due.delete();
		end else begin
			if (mem_read) begin
				pend_addr.push_back(mem_addr);
				pend_due.push_back(cycle + MEM_LATENCY - 1); // seen by the DUT at edge +latency
			end
			if (mem_write) begin
				mem[mem_addr[ADDR_W-1:1]] = mem_write_data;
				write_count++;
				last_write_addr = mem_addr;
				last_write_data = mem_write_data;
			end
		end
	end

	always @(negedge clk) begin
		if (pend_due.size() > 0 && pend_due[0] <= cycle) begin
			mem_data_valid <= 1'b1;
			mem_read_data  <= mem[pend_addr[0][ADDR_W-1:1]];
			void'(pend_addr.pop_front());
			void'(pend_due.pop_front());
		end else begin
			mem_data_valid <= 1'b0;
		end
	end

	initial begin
		repeat (20 + REQUESTS * CYCLES_PER_REQUEST) @(posedge clk); // 20 for two resets
		$display("timeout: requests did not complete within the cycle budget");
		$display("Testbench failed");
		$finish;
	end

	// mixes every address bit so neighbouring words differ
	function automatic word_t word_hash(input int unsigned i);
		return word_t'((i * 32'h9e37_79b1) >> 13) ^ word_t'(i);
	endfunction

	function automatic word_t mirror_at(input addr_t a);
		return mirror[a[ADDR_W-1:1]]; // byte bit ignored
	endfunction

	// galois lfsr, one step per bit handed out
	function automatic logic [31:0] next_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			v    = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return v;
	endfunction

	task automatic check_word(input string name, input word_t exp, input word_t act);
		checks++;
		assert (act === exp) else begin
			$display("Fail %s: expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_true(input string name, input bit cond, input string what);
		checks++;
		assert (cond) else begin
			$display("%s: %s", name, what);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int start);
		tests++;
		if (errors == start) $display("%s: ok", name);
		else $display("%s: %0d errors", name, errors - start);
	endtask

	task automatic apply_reset();
		@(negedge clk);
		reset = 1'b1;
		repeat (10) @(negedge clk);
		reset = 1'b0;
	endtask

	// one request held until stall drops, cycles = 1 means same-cycle hit
	task automatic access(input bit d_port, input bit store, input addr_t a, input word_t wd,
			output word_t rd, output int cycles);
		@(negedge clk);
		if (d_port) begin
			d_read       = !store;
			d_write      = store;
			d_addr       = a;
			d_write_data = wd;
		end else begin
			i_read = 1'b1;
			i_addr = a;
		end
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
		end while (d_port ? d_stall : i_stall);
		rd = d_port ? d_read_data : i_read_data; // sampled before the edge updates
		@(negedge clk);
		d_read  = 1'b0;
		d_write = 1'b0;
		i_read  = 1'b0;
		if (store) mirror[a[ADDR_W-1:1]] = wd;
	endtask

	task automatic ifetch_miss_then_hits();
		int    start;
		int    cycles;
		word_t rd;
		addr_t a;
		start = errors;
		a     = 16'h8120;
		access(1'b0, 1'b0, a, '0, rd, cycles);
		check_true("ifetch", cycles > 1, "first fetch of a block did not stall");
		check_word("ifetch", mirror_at(a), rd);
		for (int b = 0; b < 16; b++) begin // every byte offset, odd ones too
			a = 16'h8120 | addr_t'(b);
			access(1'b0, 1'b0, a, '0, rd, cycles);
			check_true("ifetch", cycles == 1, "re-read of a cached block stalled");
			check_word("ifetch", mirror_at(a), rd);
		end
		report_test("ifetch", start);
	endtask

	task automatic store_through();
		int    start;
		int    cycles;
		int    writes;
		word_t rd;
		start = errors;
		access(1'b1, 1'b0, 16'h0340, '0, rd, cycles); // bring the block in
		writes = write_count;
		access(1'b1, 1'b1, 16'h0346, 16'hbeef, rd, cycles);
		check_true("store", cycles == 1, "store to a cached block stalled");
		check_true("store", write_count == writes + 1, "store hit made the wrong write count");
		check_word("store", 16'h0346, last_write_addr);
		check_word("store", 16'hbeef, last_write_data);
		access(1'b1, 1'b0, 16'h0346, '0, rd, cycles);
		check_word("store", mirror_at(16'h0346), rd);
		writes = write_count;
		access(1'b1, 1'b1, 16'h0a52, 16'h1234, rd, cycles); // allocate on miss
		check_true("store", cycles > 1, "store miss did not fill the block first");
		check_true("store", write_count == writes + 1, "store miss made the wrong write count");
		check_word("store", 16'h0a52, last_write_addr);
		check_word("store", 16'h1234, last_write_data);
		access(1'b1, 1'b0, 16'h0a52, '0, rd, cycles);
		check_word("store", mirror_at(16'h0a52), rd);
		report_test("store", start);
	endtask

	task automatic tag_replacement();
		int    start;
		int    cycles;
		word_t rd;
		addr_t pair [2];
		start   = errors;
		pair[0] = 16'h0560; // tag 0, set 0x56
		pair[1] = 16'h2564; // tag 4, same set
		for (int n = 0; n < 4; n++) begin
			access(1'b1, 1'b0, pair[n % 2], '0, rd, cycles);
			check_true("tag_replace", cycles > 1, "conflicting block was not evicted");
			check_word("tag_replace", mirror_at(pair[n % 2]), rd);
		end
		report_test("tag_replace", start);
	endtask

	task automatic dual_miss_priority();
		int    start;
		int    t;
		int    i_done;
		int    d_done;
		word_t i_rd;
		word_t d_rd;
		start  = errors;
		t      = 0;
		i_done = 0;
		d_done = 0;
		i_rd   = '0;
		d_rd   = '0;
		@(negedge clk);
		i_read = 1'b1;
		i_addr = 16'h9700;
		d_read = 1'b1;
		d_addr = 16'h1700;
		while (i_done == 0 || d_done == 0) begin // watchdog bounds this
			@(posedge clk);
			t++;
			if (d_done == 0 && !d_stall) begin
				d_done = t;
				d_rd   = d_read_data;
			end
			if (i_done == 0 && !i_stall) begin
				i_done = t;
				i_rd   = i_read_data;
			end
		end
		@(negedge clk);
		i_read = 1'b0;
		d_read = 1'b0;
		check_word("dual_miss", mirror_at(16'h9700), i_rd);
		check_word("dual_miss", mirror_at(16'h1700), d_rd);
		check_true("dual_miss", d_done < i_done, "data cache did not complete first");
		report_test("dual_miss", start);
	endtask

	task automatic reset_clears_valid();
		int    start;
		int    cycles;
		word_t rd;
		start = errors;
		access(1'b1, 1'b0, 16'h0780, '0, rd, cycles);
		access(1'b1, 1'b0, 16'h0780, '0, rd, cycles);
		check_true("reset_valid", cycles == 1, "block was not cached before reset");
		apply_reset();
		access(1'b1, 1'b0, 16'h0780, '0, rd, cycles);
		check_true("reset_valid", cycles > 1, "block still hit after reset");
		check_word("reset_valid", mirror_at(16'h0780), rd);
		report_test("reset_valid", start);
	endtask

	task automatic random_traffic();
		int    start;
		int    cycles;
		int    writes;
		bit    d_port;
		bit    store;
		addr_t a;
		word_t wd;
		word_t rd;
		start = errors;
		for (int n = 0; n < RANDOM_OPS; n++) begin
			d_port         = next_bits(1) != 0;
			store          = d_port && (next_bits(1) != 0); // only the data port stores
			a              = addr_t'(next_bits(15));
			a[ADDR_W-1]    = !d_port; // code in the top half, data below, never shared
			wd             = word_t'(next_bits(16));
			writes         = write_count;
			access(d_port, store, a, wd, rd, cycles);
			if (store) begin
				check_true("random", write_count == writes + 1, "store made the wrong write count");
				check_word("random", a, last_write_addr);
				check_word("random", wd, last_write_data);
			end else begin
				check_word("random", mirror_at(a), rd);
			end
		end
		report_test("random", start);
	endtask

	initial begin
		reset        = 1'b1;
		i_read       = 1'b0;
		i_addr       = '0;
		d_read       = 1'b0;
		d_write      = 1'b0;
		d_addr       = '0;
		d_write_data = '0;
		mem_data_valid = 1'b0;
		mem_read_data  = '0;
		for (int i = 0; i < (1 << (ADDR_W - 1)); i++) begin
			mem[i]    = word_hash(i);
			mirror[i] = word_hash(i);
		end
		repeat (10) @(negedge clk);
		reset = 1'b0;
		ifetch_miss_then_hits();
		store_through();
		tag_replacement();
		dual_miss_priority();
		reset_clears_valid();
		random_traffic();
		check_true("assertions", u_memory_system.u_assertions.fail_count == 0,
			"a bound assertion failed");
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) $display("Testbench passed");
		else $display("Testbench failed");
		$finish;
	end

endmodule

//--- list.f
verilog/cache_pkg.sv
verilog/set_array.sv
verilog/cache_fill_fsm.sv
verilog/cache.sv
verilog/mem_arbiter.sv
verilog/memory_system.sv
test/memory_system_assertions.sv
test/memory_system_tb.sv

//--- Bender.yml
package:
  name: memory_system

sources:
  - files:
      - verilog/cache_pkg.sv
      - verilog/set_array.sv
      - verilog/cache_fill_fsm.sv
      - verilog/cache.sv
      - verilog/mem_arbiter.sv
      - verilog/memory_system.sv
  - target: test
    files:
      - test/memory_system_assertions.sv
      - test/memory_system_tb.sv
